// ==== verilog.f ====
rtl/i3c_hdr_pkg.sv
rtl/hdr_regf.sv
rtl/hdr_engine.sv
rtl/ccc_handler.sv
rtl/ddr_mode.sv
rtl/i3c_hdr_top.sv
tests/tb_i3c_hdr.sv

// ==== Bender.yml ====
package:
  name: i3c_hdr

sources:
  # package first, then leaf blocks, then the top level
  - files:
      - rtl/i3c_hdr_pkg.sv
      - rtl/hdr_regf.sv
      - rtl/hdr_engine.sv
      - rtl/ccc_handler.sv
      - rtl/ddr_mode.sv
      - rtl/i3c_hdr_top.sv
  # testbench, top module tb_i3c_hdr
  - target: test
    files:
      - tests/tb_i3c_hdr.sv

// ==== tests/tb_i3c_hdr.sv ====
`timescale 1ns/10ps

module tb_i3c_hdr import i3c_hdr_pkg::*; ();

  logic       i_sys_clk;
  logic       i_sys_rst_n;
  logic       i_hdr_en;
  hdr_cmd_t   i_cmd;
  regf_wr_t   i_regf_wr;
  ddr_word_t  o_word;
  logic       o_word_valid;
  logic       o_cmd_ack;
  logic       o_hdr_done;

  integer     seed = 30467;
  int         word_err = 0;   // wrong or unexpected words
  int         other_err = 0;  // counts, timeouts, reset values
  int         ack_cnt = 0;
  int         done_cnt = 0;
  logic [7:0] mem_model [REGF_DEPTH];  // bytes as the host wrote them
  ddr_word_t  exp_q [$];               // predicted words, oldest first
  ddr_word_t  exp_head;
  logic       exp_avail;

  i3c_hdr_top u_dut (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst_n  (i_sys_rst_n),
    .i_hdr_en     (i_hdr_en),
    .i_cmd        (i_cmd),
    .i_regf_wr    (i_regf_wr),
    .o_word       (o_word),
    .o_word_valid (o_word_valid),
    .o_cmd_ack    (o_cmd_ack),
    .o_hdr_done   (o_hdr_done)
  );

  initial i_sys_clk = 1'b0;
  always #50 i_sys_clk = ~i_sys_clk;  // 100 ns period

  // word from the line rules: odd payload bits xor, even bits xnor
  function automatic ddr_word_t model_word(input ddr_preamble_e pre, input logic [15:0] pl);
    ddr_word_t w;
    w.preamble = pre;
    w.payload  = pl;
    w.parity   = {^(pl & 16'haaaa), ~(^(pl & 16'h5555))};
    return w;
  endfunction

  function automatic hdr_cmd_t make_cmd(input logic cp, input logic toc,
                                        input logic [7:0] code, input logic [3:0] len);
    hdr_cmd_t c;
    c.cp       = cp;
    c.toc      = toc;
    c.mode     = HDR_DDR_MODE;
    c.ccc_code = code;
    c.data_len = len;
    return c;
  endfunction

  function automatic void update_head();
    exp_avail = (exp_q.size() != 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  endfunction

  // command word: code on top, special byte below
  task automatic push_ccc(input logic [7:0] code, input int addr);
    exp_q.push_back(model_word(PRE_CMD, {code, mem_model[addr]}));
    update_head();
  endtask

  task automatic push_data(input int len);
    for (int k = 0; k < len; k++) begin
      exp_q.push_back(model_word(PRE_DATA, {mem_model[2*k], mem_model[2*k+1]}));
    end
    update_head();
  endtask

  task automatic check_val(input string name, input int exp, input int act);
    assert (exp == act) else begin
      other_err++;
      $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge i_sys_clk);
  endtask

  task automatic load_regf();
    logic [7:0] b;
    for (int i = 0; i < REGF_DEPTH; i++) begin
      @(negedge i_sys_clk);
      b            = $random(seed);
      mem_model[i] = b;
      i_regf_wr    = '{we: 1'b1, addr: i[REGF_AW-1:0], data: b};
    end
    @(negedge i_sys_clk);
    i_regf_wr = '0;
  endtask

  // returns on the falling edge inside the first valid cycle
  task automatic wait_first_word();
    bit seen;
    seen = 1'b0;
    for (int cyc = 0; cyc < 50 && !seen; cyc++) begin
      @(negedge i_sys_clk);
      seen = o_word_valid;
    end
    if (!seen) begin
      other_err++;
      $display("timeout: no word appeared within 50 cycles at t=%0t", $time);
    end
  endtask

  task automatic wait_hdr_done();
    bit seen;
    seen = 1'b0;
    for (int cyc = 0; cyc < 50 && !seen; cyc++) begin
      @(negedge i_sys_clk);
      seen = o_hdr_done;
    end
    if (!seen) begin
      other_err++;
      $display("timeout: no o_hdr_done within 50 cycles at t=%0t", $time);
    end
  endtask

  // one or two descriptors, second one goes in on o_cmd_ack
  task automatic run_seq(input hdr_cmd_t c0, input hdr_cmd_t c1, input int n_cmd);
    int ack0;
    int done0;
    int idx;
    bit seen;
    ack0  = ack_cnt;
    done0 = done_cnt;
    idx   = 1;
    seen  = 1'b0;
    @(negedge i_sys_clk);
    i_cmd    = c0;
    i_hdr_en = 1'b1;
    for (int cyc = 0; cyc < 200 && !seen; cyc++) begin
      @(negedge i_sys_clk);
      if (o_cmd_ack && idx < n_cmd) begin
        i_cmd = c1;  // engine picks it up on the next rising edge
        idx++;
      end
      seen = o_hdr_done;
    end
    if (!seen) begin
      other_err++;
      $display("timeout: no o_hdr_done within 200 cycles at t=%0t", $time);
    end
    i_hdr_en = 1'b0;
    idle_cycles(4);
    check_val("o_cmd_ack pulses", n_cmd - 1, ack_cnt - ack0);
    check_val("o_hdr_done pulses", 1, done_cnt - done0);
    check_val("words left in model", 0, exp_q.size());
    exp_q.delete();  // no cascade into the next case
    update_head();
  endtask

  // pulse counters and model pop, old values seen at the rising edge
  always @(posedge i_sys_clk) begin
    if (i_sys_rst_n) begin
      if (o_cmd_ack) begin
        ack_cnt++;
      end
      if (o_hdr_done) begin
        done_cnt++;
      end
      if (o_word_valid && exp_avail) begin
        void'(exp_q.pop_front());
        update_head();
      end
    end
  end

  a_word_known: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      o_word_valid |-> exp_avail)
    else begin
      word_err++;
      $display("unexpected word on o_word with nothing predicted at t=%0t", $time);
    end

  a_word_value: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      (o_word_valid && exp_avail) |-> (o_word == exp_head))
    else begin
      word_err++;
      $display("FAILED t=%0t o_word expected %h got %h", $time, $sampled(exp_head),
               $sampled(o_word));
    end

  // two cycles of slack for a pass already in flight when enable drops
  a_quiet_off: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
      (!i_hdr_en && !$past(i_hdr_en) && !$past(i_hdr_en, 2)) |->
      !(o_word_valid || o_cmd_ack || o_hdr_done))
    else begin
      other_err++;
      $display("output activity while i_hdr_en is low at t=%0t", $time);
    end

  initial begin
    int         done0;
    logic [7:0] code_a;
    logic [7:0] code_b;
    i_sys_rst_n = 1'b0;
    i_hdr_en    = 1'b0;
    i_cmd       = '0;
    i_regf_wr   = '0;
    update_head();
    repeat (8) @(negedge i_sys_clk);
    i_sys_rst_n = 1'b1;
    check_val("o_word_valid", 0, o_word_valid);  // everything quiet out of reset
    check_val("o_cmd_ack", 0, o_cmd_ack);
    check_val("o_hdr_done", 0, o_hdr_done);
    check_val("o_word", 0, o_word);
    load_regf();  // 16 cycles with enable low
    code_a = $random(seed);
    code_b = $random(seed);
    push_ccc(code_a, SPECIAL_ADDR_NORMAL);  // single ccc, exit
    run_seq(make_cmd(1'b1, 1'b1, code_a, 4'd1), '0, 1);
    for (int len = 1; len <= 8; len++) begin
      push_data(len);  // normal transfers of every length
      run_seq(make_cmd(1'b0, 1'b1, code_b, len[3:0]), '0, 1);
    end
    push_ccc(code_a, SPECIAL_ADDR_NORMAL);  // ccc restart into normal, dummy word
    push_ccc(code_b, SPECIAL_ADDR_DUMMY);   // carries the new descriptor's code
    push_data(4);
    run_seq(make_cmd(1'b1, 1'b0, code_a, 4'd1), make_cmd(1'b0, 1'b1, code_b, 4'd4), 2);
    push_data(2);  // normal restart into ccc
    push_ccc(code_b, SPECIAL_ADDR_NORMAL);
    run_seq(make_cmd(1'b0, 1'b0, code_a, 4'd2), make_cmd(1'b1, 1'b1, code_b, 4'd1), 2);
    push_ccc(code_a, SPECIAL_ADDR_NORMAL);  // ccc restart into ccc
    push_ccc(code_b, SPECIAL_ADDR_NORMAL);
    run_seq(make_cmd(1'b1, 1'b0, code_a, 4'd1), make_cmd(1'b1, 1'b1, code_b, 4'd1), 2);
    // bad mode after the first data word
    push_data(1);
    done0 = done_cnt;
    @(negedge i_sys_clk);
    i_cmd    = make_cmd(1'b0, 1'b1, code_a, 4'd8);
    i_hdr_en = 1'b1;
    wait_first_word();
    i_cmd.mode = 3'd3;  // next edge is a high byte read, no word due
    wait_hdr_done();
    i_hdr_en = 1'b0;
    idle_cycles(4);
    check_val("o_hdr_done pulses", 1, done_cnt - done0);
    check_val("words left in model", 0, exp_q.size());
    // enable dropped mid transfer
    push_data(1);
    done0 = done_cnt;
    @(negedge i_sys_clk);
    i_cmd    = make_cmd(1'b0, 1'b1, code_a, 4'd8);
    i_hdr_en = 1'b1;
    wait_first_word();
    i_hdr_en = 1'b0;
    idle_cycles(6);
    check_val("o_hdr_done pulses", 0, done_cnt - done0);
    check_val("words left in model", 0, exp_q.size());
    $display("errors: word %0d, other %0d", word_err, other_err);
    if (word_err == 0 && other_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== rtl/i3c_hdr_top.sv ====
`timescale 1ns/10ps

module i3c_hdr_top import i3c_hdr_pkg::*; (
  input  logic      i_sys_clk,
  input  logic      i_sys_rst_n,
  input  logic      i_hdr_en,
  input  hdr_cmd_t  i_cmd,         // stable until o_cmd_ack
  input  regf_wr_t  i_regf_wr,
  output ddr_word_t o_word,
  output logic      o_word_valid,
  output logic      o_cmd_ack,
  output logic      o_hdr_done
);

  logic               ccc_en;
  logic               ddr_en;
  logic               ccc_done;
  logic               ddr_done;
  logic [REGF_AW-1:0] special_addr;
  logic [REGF_AW-1:0] ccc_raddr;
  logic [REGF_AW-1:0] ddr_raddr;
  logic [7:0]         ccc_rdata;
  logic [7:0]         ddr_rdata;
  ddr_word_t          ccc_word;
  ddr_word_t          ddr_word;
  logic               ccc_valid;
  logic               ddr_valid;
  logic [$bits(ddr_word_t)-1:0] ccc_bits;
  logic [$bits(ddr_word_t)-1:0] ddr_bits;

  hdr_regf u_regf (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_wr        (i_regf_wr),
    .i_raddr_a   (ccc_raddr),
    .o_rdata_a   (ccc_rdata),
    .i_raddr_b   (ddr_raddr),
    .o_rdata_b   (ddr_rdata)
  );

  hdr_engine u_engine (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst_n    (i_sys_rst_n),
    .i_hdr_en       (i_hdr_en),
    .i_cmd          (i_cmd),
    .i_ccc_done     (ccc_done),
    .i_ddr_done     (ddr_done),
    .o_ccc_en       (ccc_en),
    .o_ddr_en       (ddr_en),
    .o_special_addr (special_addr),
    .o_cmd_ack      (o_cmd_ack),
    .o_hdr_done     (o_hdr_done)
  );

  ccc_handler u_ccc (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst_n    (i_sys_rst_n),
    .i_ccc_en       (ccc_en),
    .i_ccc_code     (i_cmd.ccc_code),
    .i_special_addr (special_addr),
    .o_raddr        (ccc_raddr),
    .i_rdata        (ccc_rdata),
    .o_word         (ccc_word),
    .o_word_valid   (ccc_valid),
    .o_ccc_done     (ccc_done)
  );

  ddr_mode u_ddr (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst_n  (i_sys_rst_n),
    .i_ddr_en     (ddr_en),
    .i_data_len   (i_cmd.data_len),
    .o_raddr      (ddr_raddr),
    .i_rdata      (ddr_rdata),
    .o_word       (ddr_word),
    .o_word_valid (ddr_valid),
    .o_ddr_done   (ddr_done)
  );

  // only one block runs at a time, gated or is enough
  assign ccc_bits     = ccc_valid ? ccc_word : '0;
  assign ddr_bits     = ddr_valid ? ddr_word : '0;
  assign o_word       = ddr_word_t'(ccc_bits | ddr_bits);
  assign o_word_valid = ccc_valid | ddr_valid;

endmodule

// ==== rtl/ddr_mode.sv ====
`timescale 1ns/10ps

module ddr_mode import i3c_hdr_pkg::*; (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst_n,
  input  logic               i_ddr_en,     // level from engine
  input  logic [3:0]         i_data_len,   // words to send, 1..8
  output logic [REGF_AW-1:0] o_raddr,
  input  logic [7:0]         i_rdata,
  output ddr_word_t          o_word,
  output logic               o_word_valid,
  output logic               o_ddr_done
);

  logic               en_q;
  logic               active;    // words still to go
  logic               start;
  logic               busy;
  logic               last_word;
  logic [REGF_AW-1:0] rd_ptr;    // byte pointer, bit 0 = low byte phase
  logic [3:0]         word_cnt;  // words already sent
  logic [7:0]         hi_byte;
  logic [15:0]        data_payload;

  assign start        = i_ddr_en & ~en_q;
  assign busy         = i_ddr_en & (start | active);
  assign last_word    = (word_cnt + 4'd1) == i_data_len;
  assign o_raddr      = rd_ptr;
  assign data_payload = {hi_byte, i_rdata};  // low byte straight off the port

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_q         <= 1'b0;
      active       <= 1'b0;
      rd_ptr       <= '0;
      word_cnt     <= '0;
      o_word_valid <= 1'b0;
      o_ddr_done   <= 1'b0;
    end else begin
      en_q         <= i_ddr_en;
      o_word_valid <= 1'b0;
      o_ddr_done   <= 1'b0;
      if (!i_ddr_en) begin
        active   <= 1'b0;  // park at byte 0 for the next pass
        rd_ptr   <= '0;
        word_cnt <= '0;
      end else if (busy) begin
        rd_ptr <= rd_ptr + 1'b1;
        if (start) begin
          active <= 1'b1;
        end
        if (rd_ptr[0]) begin
          // low byte cycle, word leaves on this edge
          o_word_valid <= 1'b1;
          word_cnt     <= word_cnt + 4'd1;
          if (last_word) begin
            o_ddr_done <= 1'b1;  // with the last word
            active     <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (busy && !rd_ptr[0]) begin
      hi_byte <= i_rdata;  // byte 2k
    end
    if (busy && rd_ptr[0]) begin
      o_word.preamble <= PRE_DATA;
      o_word.payload  <= data_payload;
      o_word.parity   <= ddr_parity(data_payload);
    end
  end

endmodule

// ==== rtl/ccc_handler.sv ====
`timescale 1ns/10ps

module ccc_handler import i3c_hdr_pkg::*; (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst_n,
  input  logic               i_ccc_en,        // level from engine
  input  logic [7:0]         i_ccc_code,
  input  logic [REGF_AW-1:0] i_special_addr,  // 10 normal, 9 dummy
  output logic [REGF_AW-1:0] o_raddr,
  input  logic [7:0]         i_rdata,
  output ddr_word_t          o_word,
  output logic               o_word_valid,
  output logic               o_ccc_done
);

  logic        en_q;         // enable delayed, for edge detect
  logic        rd_pend;      // special byte captured, word goes out next
  logic        start;
  logic [7:0]  rd_byte;
  logic [15:0] cmd_payload;

  assign start       = i_ccc_en & ~en_q;
  assign o_raddr     = i_special_addr;  // read port follows the engine's choice
  assign cmd_payload = {i_ccc_code, rd_byte};

  // control: rise -> read cycle -> emit cycle
  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_q         <= 1'b0;
      rd_pend      <= 1'b0;
      o_word_valid <= 1'b0;
    end else begin
      en_q         <= i_ccc_en;
      o_word_valid <= 1'b0;
      if (!i_ccc_en) begin
        rd_pend <= 1'b0;  // dropped enable aborts the pass
      end else if (start) begin
        rd_pend <= 1'b1;
      end else if (rd_pend) begin
        rd_pend      <= 1'b0;
        o_word_valid <= 1'b1;
      end
    end
  end

  // payload path
  always_ff @(posedge i_sys_clk) begin
    if (start) begin
      rd_byte <= i_rdata;  // byte at the special address
    end
    if (rd_pend && i_ccc_en) begin
      o_word.preamble <= PRE_CMD;
      o_word.payload  <= cmd_payload;  // code in high byte
      o_word.parity   <= ddr_parity(cmd_payload);
    end
  end

  // one word per pass, so done rides on the valid strobe
  assign o_ccc_done = o_word_valid;

endmodule

// ==== rtl/hdr_engine.sv ====
`timescale 1ns/10ps

module hdr_engine import i3c_hdr_pkg::*; (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst_n,
  input  logic               i_hdr_en,        // level, hdr operation on
  input  hdr_cmd_t           i_cmd,           // current descriptor
  input  logic               i_ccc_done,      // pulse from ccc_handler
  input  logic               i_ddr_done,      // pulse from ddr_mode
  output logic               o_ccc_en,
  output logic               o_ddr_en,
  output logic [REGF_AW-1:0] o_special_addr,  // byte for the command word
  output logic               o_cmd_ack,       // host may present next descriptor
  output logic               o_hdr_done
);

  hdr_state_e state;
  logic       dummy_pend;  // dummy ccc pass running before a ddr pass
  logic       mode_bad;
  logic       exit_now;

  // any non hdr-ddr mode seen while a block runs aborts the sequence
  assign mode_bad = (i_cmd.mode != HDR_DDR_MODE) && (o_ccc_en || o_ddr_en);

  // toc of the descriptor belongs to the ddr pass during a dummy pass,
  // so a dummy done never exits
  assign exit_now = mode_bad ||
                    (o_ccc_en && i_ccc_done && i_cmd.toc && !dummy_pend) ||
                    (o_ddr_en && i_ddr_done && i_cmd.toc);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state          <= IDLE;
      o_ccc_en       <= 1'b0;
      o_ddr_en       <= 1'b0;
      o_special_addr <= SPECIAL_ADDR_NORMAL;
      o_cmd_ack      <= 1'b0;
      o_hdr_done     <= 1'b0;
      dummy_pend     <= 1'b0;
    end else begin
      o_cmd_ack  <= 1'b0;  // pulses
      o_hdr_done <= 1'b0;
      if (!i_hdr_en) begin
        // disable wins over everything, no done pulse
        state      <= IDLE;
        o_ccc_en   <= 1'b0;
        o_ddr_en   <= 1'b0;
        dummy_pend <= 1'b0;
      end else if (exit_now) begin
        o_ccc_en   <= 1'b0;
        o_ddr_en   <= 1'b0;
        dummy_pend <= 1'b0;
        o_hdr_done <= 1'b1;
        state      <= EXIT;
      end else begin
        case (state)
          IDLE: begin
            // first pass straight from the descriptor, no dummy here
            if (i_cmd.cp) begin
              o_ccc_en       <= 1'b1;
              o_special_addr <= SPECIAL_ADDR_NORMAL;
              state          <= CCC;
            end else begin
              o_ddr_en <= 1'b1;
              state    <= DDR_MODE;
            end
          end
          CCC: begin
            if (o_ccc_en) begin
              if (i_ccc_done && dummy_pend) begin
                // dummy word sent, go on with the data words
                o_ccc_en   <= 1'b0;
                o_ddr_en   <= 1'b1;
                dummy_pend <= 1'b0;
                state      <= DDR_MODE;
              end else if (i_ccc_done) begin
                o_ccc_en  <= 1'b0;  // restart, ask for next descriptor
                o_cmd_ack <= 1'b1;
              end
            end else begin
              // gap cycle after ack, i_cmd now holds the new descriptor
              o_ccc_en <= 1'b1;
              if (i_cmd.cp) begin
                o_special_addr <= SPECIAL_ADDR_NORMAL;
              end else begin
                o_special_addr <= SPECIAL_ADDR_DUMMY;  // ccc -> normal, insert dummy
                dummy_pend     <= 1'b1;
              end
            end
          end
          DDR_MODE: begin
            if (o_ddr_en) begin
              if (i_ddr_done) begin
                o_ddr_en  <= 1'b0;
                o_cmd_ack <= 1'b1;
              end
            end else if (i_cmd.cp) begin
              o_ccc_en       <= 1'b1;  // ddr -> ccc needs no dummy
              o_special_addr <= SPECIAL_ADDR_NORMAL;
              state          <= CCC;
            end else begin
              o_ddr_en <= 1'b1;
            end
          end
          EXIT: begin
            state <= EXIT;  // parked until the host drops i_hdr_en
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

// ==== rtl/hdr_regf.sv ====
`timescale 1ns/10ps

module hdr_regf import i3c_hdr_pkg::*; (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst_n,
  input  regf_wr_t           i_wr,       // host write port
  input  logic [REGF_AW-1:0] i_raddr_a,  // ccc side
  output logic [7:0]         o_rdata_a,
  input  logic [REGF_AW-1:0] i_raddr_b,  // ddr side
  output logic [7:0]         o_rdata_b
);

  logic [7:0] mem [REGF_DEPTH];

  // byte array, cleared on reset so the special bytes start known
  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      for (int i = 0; i < REGF_DEPTH; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (i_wr.we) begin
      mem[i_wr.addr] <= i_wr.data;  // one byte per edge
    end
  end

  // both read ports are plain muxes, no read latency here
  assign o_rdata_a = mem[i_raddr_a];
  assign o_rdata_b = mem[i_raddr_b];

  // note: the transfer blocks register the read data themselves,
  // so the one-cycle read in their timing lives on their side

endmodule

// ==== rtl/i3c_hdr_pkg.sv ====
package i3c_hdr_pkg;

  // register file geometry
  localparam int unsigned REGF_DEPTH = 16;  // bytes
  localparam int unsigned REGF_AW    = 4;   // byte address width

  localparam logic [2:0] HDR_DDR_MODE = 3'd6;  // mode code for HDR-DDR

  // special register addresses for the command word byte
  localparam logic [REGF_AW-1:0] SPECIAL_ADDR_NORMAL = 4'd10;
  localparam logic [REGF_AW-1:0] SPECIAL_ADDR_DUMMY  = 4'd9;  // dummy word on ccc->ddr restart

  // sequencer states
  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    CCC      = 2'b01,
    DDR_MODE = 2'b10,
    EXIT     = 2'b11
  } hdr_state_e;

  // 2-bit preamble in front of every hdr-ddr word
  typedef enum logic [1:0] {
    PRE_CMD  = 2'b01,  // command word
    PRE_DATA = 2'b10   // data word
  } ddr_preamble_e;

  // command descriptor from host, 17 bits
  typedef struct packed {
    logic       cp;        // 1 = ccc, 0 = normal transfer
    logic       toc;       // 1 = exit after this transfer, 0 = restart
    logic [2:0] mode;
    logic [7:0] ccc_code;
    logic [3:0] data_len;  // data words, 1..8
  } hdr_cmd_t;

  // one hdr-ddr word, 20 bits on the line
  typedef struct packed {
    ddr_preamble_e preamble;
    logic [15:0]   payload;
    logic [1:0]    parity;
  } ddr_word_t;

  // host write into register file
  typedef struct packed {
    logic               we;
    logic [REGF_AW-1:0] addr;
    logic [7:0]         data;
  } regf_wr_t;

  // parity pair: [1] = xor of odd payload bits, [0] = inverted xor of even bits
  function automatic logic [1:0] ddr_parity(input logic [15:0] data);
    logic p_odd;
    logic p_even;
    p_odd  = 1'b0;
    p_even = 1'b0;
    for (int i = 0; i < 16; i += 2) begin
      p_even ^= data[i];
      p_odd  ^= data[i+1];
    end
    return {p_odd, ~p_even};
  endfunction

endpackage
